/* hdl/hsid_pkg.sv */
`default_nettype none

package hsid_pkg;

  localparam int HSID_WORD_WIDTH     = 32;  // Memory word and host address
  localparam int HSID_MEM_ADDR_WIDTH = 12;  // 4096 words
  localparam int HSID_BANDS_WIDTH    = 7;   // Up to 127 bands
  localparam int HSID_LIBRARY_WIDTH  = 6;   // Up to 63 library pixels
  localparam int HSID_ACCESS_WIDTH   = HSID_BANDS_WIDTH + HSID_LIBRARY_WIDTH;
  localparam int HSID_SAMPLE_WIDTH   = 16;
  localparam int HSID_SSE_WIDTH      = 40;  // Sum of squared differences

  // One memory word, seen raw or as two band samples (even band in the low half)
  typedef union packed {
    logic [HSID_WORD_WIDTH-1:0]              raw;
    logic [1:0][HSID_SAMPLE_WIDTH-1:0]       sample;
  } hsid_pack_u;

  typedef enum logic [2:0] {
    IDLE,
    CONFIG,
    START_READ_CAPTURED,
    READ_CAPTURED,
    START_READ_LIBRARY,
    READ_LIBRARY,
    CLEAR
  } hsid_state_t;

endpackage

`default_nettype wire

/* hdl/hsid_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module hsid_sequencer (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    start,
  input  logic                                    clear,
  input  logic                                    error,
  input  logic [hsid_pkg::HSID_BANDS_WIDTH-1:0]   hsp_bands,
  input  logic [hsid_pkg::HSID_LIBRARY_WIDTH-1:0] hsp_library_size,
  input  logic [hsid_pkg::HSID_WORD_WIDTH-1:0]    captured_pixel_addr,
  input  logic [hsid_pkg::HSID_WORD_WIDTH-1:0]    library_pixel_addr,
  input  logic                                    rd_done,
  output logic                                    rd_start,
  output logic [hsid_pkg::HSID_WORD_WIDTH-1:0]    rd_base_addr,
  output logic [hsid_pkg::HSID_ACCESS_WIDTH-1:0]  rd_count,
  output logic                                    rd_abort,
  output logic                                    phase_capture,
  output logic                                    phase_library,
  output logic [hsid_pkg::HSID_BANDS_WIDTH-1:0]   band_packs,
  output logic                                    run_start,
  output logic                                    done,
  output logic                                    aborting
);

  import hsid_pkg::*;

  hsid_state_t                  state;
  hsid_state_t                  next_state;
  logic                         cancel;
  logic [HSID_WORD_WIDTH-1:0]   cfg_captured_addr;
  logic [HSID_WORD_WIDTH-1:0]   cfg_library_addr;
  logic [HSID_LIBRARY_WIDTH-1:0] cfg_library_size;

  assign cancel        = clear | error;
  assign rd_abort      = cancel;                // Level, drops the reader back to idle
  assign run_start     = state == CONFIG;
  assign phase_capture = state == READ_CAPTURED;
  assign phase_library = state == READ_LIBRARY;
  assign aborting      = state == CLEAR;

  always_comb begin
    next_state = state;
    case (state)
      IDLE:                next_state = (start && !clear) ? CONFIG : IDLE;
      CONFIG:              next_state = cancel ? CLEAR : START_READ_CAPTURED;
      START_READ_CAPTURED: next_state = cancel ? CLEAR : READ_CAPTURED;
      READ_CAPTURED: begin
        if (cancel) next_state = CLEAR;
        else if (rd_done) next_state = START_READ_LIBRARY;
      end
      START_READ_LIBRARY:  next_state = cancel ? CLEAR : READ_LIBRARY;
      READ_LIBRARY: begin
        if (cancel) next_state = CLEAR;
        else if (rd_done) next_state = IDLE;
      end
      CLEAR:               next_state = IDLE;
      default:             next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      rd_start <= 1'b0;
      done     <= 1'b0;
    end else begin
      state    <= next_state;
      rd_start <= !cancel && (state == START_READ_CAPTURED || state == START_READ_LIBRARY);
      done     <= !cancel && state == READ_LIBRARY && rd_done;  // High on the first IDLE cycle
    end
  end

  // Configuration and read descriptors
  always_ff @(posedge clk) begin
    if (state == CONFIG) begin
      cfg_captured_addr <= captured_pixel_addr;
      cfg_library_addr  <= library_pixel_addr;
      cfg_library_size  <= hsp_library_size;
      band_packs        <= HSID_BANDS_WIDTH'(hsp_bands[HSID_BANDS_WIDTH-1:1])
                           + HSID_BANDS_WIDTH'(hsp_bands[0]);  // Bands / 2 rounded up
    end
    if (state == START_READ_CAPTURED) begin
      rd_base_addr <= cfg_captured_addr;
      rd_count     <= HSID_ACCESS_WIDTH'(band_packs);
    end else if (state == START_READ_LIBRARY) begin
      rd_base_addr <= cfg_library_addr;
      rd_count     <= band_packs * cfg_library_size;
    end
  end

  // Each read phase gets exactly one start
  a_single_rd_start: assert property (
    @(posedge clk) disable iff (!rst_n) rd_start |=> !rd_start
  );

endmodule

`default_nettype wire

/* hdl/hsid_mem_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module hsid_mem_reader (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   rd_start,
  input  logic [hsid_pkg::HSID_WORD_WIDTH-1:0]   rd_base_addr,
  input  logic [hsid_pkg::HSID_ACCESS_WIDTH-1:0] rd_count,
  input  logic                                   rd_abort,
  input  logic                                   rd_gnt,
  input  logic                                   mem_rvalid,
  output logic                                   rd_req,
  output logic [hsid_pkg::HSID_WORD_WIDTH-1:0]   rd_addr,
  output logic                                   rd_done
);

  import hsid_pkg::*;

  logic                         busy;
  logic [HSID_ACCESS_WIDTH-1:0] issue_left;  // Reads still to issue
  logic [HSID_ACCESS_WIDTH-1:0] resp_left;   // Responses still expected
  logic                         issue;

  assign rd_req = busy && issue_left != '0 && !rd_abort;
  assign issue  = rd_req && rd_gnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      issue_left <= '0;
      resp_left  <= '0;
      rd_done    <= 1'b0;
    end else begin
      rd_done <= 1'b0;
      if (rd_abort) begin
        busy       <= 1'b0;
        issue_left <= '0;
        resp_left  <= '0;
      end else if (rd_start) begin
        busy       <= rd_count != '0;
        issue_left <= rd_count;
        resp_left  <= rd_count;
        rd_done    <= rd_count == '0;  // Empty transfer completes at once
      end else if (busy) begin
        if (issue) issue_left <= issue_left - 1'b1;
        if (mem_rvalid) begin
          resp_left <= resp_left - 1'b1;
          if (resp_left == HSID_ACCESS_WIDTH'(1)) begin
            busy    <= 1'b0;
            rd_done <= 1'b1;
          end
        end
      end
    end
  end

  // Address only moves on an accepted read
  always_ff @(posedge clk) begin
    if (rd_start) rd_addr <= rd_base_addr;
    else if (issue) rd_addr <= rd_addr + 1'b1;
  end

  a_start_when_idle: assert property (
    @(posedge clk) disable iff (!rst_n) rd_start |-> !busy
  );

endmodule

`default_nettype wire

/* hdl/hsid_mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module hsid_mem_arbiter (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     host_we,
  input  logic [hsid_pkg::HSID_WORD_WIDTH-1:0]     host_addr,
  input  logic [hsid_pkg::HSID_WORD_WIDTH-1:0]     host_wdata,
  input  logic                                     rd_req,
  input  logic [hsid_pkg::HSID_WORD_WIDTH-1:0]     rd_addr,
  output logic                                     rd_gnt,
  output logic                                     mem_en,
  output logic                                     mem_we,
  output logic [hsid_pkg::HSID_MEM_ADDR_WIDTH-1:0] mem_addr,
  output hsid_pkg::hsid_pack_u                     mem_wdata
);

  import hsid_pkg::*;

  assign rd_gnt = rd_req && !host_we;  // Host always wins
  assign mem_en = host_we || rd_req;
  assign mem_we = host_we;

  always_comb begin
    mem_wdata.raw = host_wdata;
    if (host_we) mem_addr = host_addr[HSID_MEM_ADDR_WIDTH-1:0];
    else mem_addr = rd_addr[HSID_MEM_ADDR_WIDTH-1:0];
  end

  // A read that loses to the host keeps its address for the retry
  a_stalled_read_held: assert property (
    @(posedge clk) disable iff (!rst_n) rd_req && !rd_gnt |=> $stable(rd_addr)
  );

endmodule

`default_nettype wire

/* hdl/hsid_pixel_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module hsid_pixel_mem (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     mem_en,
  input  logic                                     mem_we,
  input  logic [hsid_pkg::HSID_MEM_ADDR_WIDTH-1:0] mem_addr,
  input  hsid_pkg::hsid_pack_u                     mem_wdata,
  output hsid_pkg::hsid_pack_u                     mem_rdata,
  output logic                                     mem_rvalid
);

  import hsid_pkg::*;

  logic [HSID_WORD_WIDTH-1:0] words [2**HSID_MEM_ADDR_WIDTH];

  always_ff @(posedge clk) begin
    if (mem_en) begin
      if (mem_we) words[mem_addr] <= mem_wdata.raw;
      else mem_rdata.raw <= words[mem_addr];  // One-cycle read latency
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) mem_rvalid <= 1'b0;
    else mem_rvalid <= mem_en && !mem_we;
  end

endmodule

`default_nettype wire

/* hdl/hsid_distance_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hsid_distance_unit (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    run_start,
  input  logic                                    phase_capture,
  input  logic                                    phase_library,
  input  logic [hsid_pkg::HSID_BANDS_WIDTH-1:0]   band_packs,
  input  logic [hsid_pkg::HSID_BANDS_WIDTH-1:0]   hsp_bands,
  input  hsid_pkg::hsid_pack_u                    mem_rdata,
  input  logic                                    mem_rvalid,
  input  logic                                    done,
  input  logic                                    abort,
  output logic                                    result_valid,
  output logic [hsid_pkg::HSID_LIBRARY_WIDTH-1:0] best_index,
  output logic [hsid_pkg::HSID_SSE_WIDTH-1:0]     best_sse
);

  import hsid_pkg::*;

  hsid_pack_u                       cap_buf [2**(HSID_BANDS_WIDTH-1)];
  hsid_pack_u                       cap_pack;
  logic [HSID_BANDS_WIDTH-1:0]      pack_ptr;
  logic [HSID_LIBRARY_WIDTH-1:0]    pixel_cnt;
  logic [HSID_SSE_WIDTH-1:0]        acc;
  logic                             last_pack;
  logic                             odd_bands;
  logic signed [HSID_SSE_WIDTH-1:0] diff_lo;
  logic signed [HSID_SSE_WIDTH-1:0] diff_hi;
  logic [HSID_SSE_WIDTH-1:0]        pixel_sum;

  assign cap_pack  = cap_buf[pack_ptr[HSID_BANDS_WIDTH-2:0]];
  assign last_pack = pack_ptr == band_packs - 1'b1;
  assign odd_bands = hsp_bands != HSID_BANDS_WIDTH'(band_packs << 1);

  always_comb begin
    diff_lo = $signed(HSID_SSE_WIDTH'(mem_rdata.sample[0]))
              - $signed(HSID_SSE_WIDTH'(cap_pack.sample[0]));
    diff_hi = $signed(HSID_SSE_WIDTH'(mem_rdata.sample[1]))
              - $signed(HSID_SSE_WIDTH'(cap_pack.sample[1]));
    if (last_pack && odd_bands) diff_hi = '0;  // Upper half past the last band
    pixel_sum = acc + $unsigned(diff_lo * diff_lo) + $unsigned(diff_hi * diff_hi);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pack_ptr     <= '0;
      pixel_cnt    <= '0;
      result_valid <= 1'b0;
    end else begin
      if (run_start || abort) begin
        pack_ptr  <= '0;
        pixel_cnt <= '0;
      end else if (mem_rvalid && (phase_capture || phase_library)) begin
        pack_ptr <= last_pack ? '0 : pack_ptr + 1'b1;  // Wraps at each pixel end
        if (phase_library && last_pack) pixel_cnt <= pixel_cnt + 1'b1;
      end
      if (run_start || abort) result_valid <= 1'b0;
      else if (done) result_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (run_start) begin
      acc        <= '0;
      best_sse   <= '1;  // Above any reachable sum
      best_index <= '0;
    end else if (mem_rvalid && phase_capture) begin
      cap_buf[pack_ptr[HSID_BANDS_WIDTH-2:0]] <= mem_rdata;
    end else if (mem_rvalid && phase_library) begin
      if (last_pack) begin
        acc <= '0;
        if (pixel_sum < best_sse) begin  // Strict, so the lower index keeps a tie
          best_sse   <= pixel_sum;
          best_index <= pixel_cnt;
        end
      end else begin
        acc <= pixel_sum;
      end
    end
  end

  // Read data only comes back while the sequencer is in a read phase
  a_rvalid_in_phase: assert property (
    @(posedge clk) disable iff (!rst_n) mem_rvalid |-> (phase_capture || phase_library)
  );

endmodule

`default_nettype wire

/* hdl/hsid_top.sv */
`timescale 1ns/1ps
`default_nettype none

module hsid_top (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    host_we,
  input  logic [hsid_pkg::HSID_WORD_WIDTH-1:0]    host_addr,
  input  logic [hsid_pkg::HSID_WORD_WIDTH-1:0]    host_wdata,
  input  logic [hsid_pkg::HSID_BANDS_WIDTH-1:0]   hsp_bands,
  input  logic [hsid_pkg::HSID_LIBRARY_WIDTH-1:0] hsp_library_size,
  input  logic [hsid_pkg::HSID_WORD_WIDTH-1:0]    captured_pixel_addr,
  input  logic [hsid_pkg::HSID_WORD_WIDTH-1:0]    library_pixel_addr,
  input  logic                                    start,
  input  logic                                    clear,
  input  logic                                    error,
  output logic                                    interrupt,
  output logic                                    result_valid,
  output logic [hsid_pkg::HSID_LIBRARY_WIDTH-1:0] best_index,
  output logic [hsid_pkg::HSID_SSE_WIDTH-1:0]     best_sse
);

  import hsid_pkg::*;

  logic                           rd_start;
  logic [HSID_WORD_WIDTH-1:0]     rd_base_addr;
  logic [HSID_ACCESS_WIDTH-1:0]   rd_count;
  logic                           rd_abort;
  logic                           rd_done;
  logic                           rd_req;
  logic                           rd_gnt;
  logic [HSID_WORD_WIDTH-1:0]     rd_addr;
  logic                           phase_capture;
  logic                           phase_library;
  logic [HSID_BANDS_WIDTH-1:0]    band_packs;
  logic                           run_start;
  logic                           done;
  logic                           aborting;
  logic                           mem_en;
  logic                           mem_we;
  logic [HSID_MEM_ADDR_WIDTH-1:0] mem_addr;
  hsid_pack_u                     mem_wdata;
  hsid_pack_u                     mem_rdata;
  logic                           mem_rvalid;

  assign interrupt = done || aborting || error;  // Pulse on done, level on abort

  hsid_sequencer u_sequencer (
    .clk, .rst_n, .start, .clear, .error, .hsp_bands, .hsp_library_size,
    .captured_pixel_addr, .library_pixel_addr, .rd_done, .rd_start, .rd_base_addr,
    .rd_count, .rd_abort, .phase_capture, .phase_library, .band_packs, .run_start,
    .done, .aborting
  );

  hsid_mem_reader u_mem_reader (
    .clk, .rst_n, .rd_start, .rd_base_addr, .rd_count, .rd_abort, .rd_gnt,
    .mem_rvalid, .rd_req, .rd_addr, .rd_done
  );

  hsid_mem_arbiter u_mem_arbiter (
    .clk, .rst_n, .host_we, .host_addr, .host_wdata, .rd_req, .rd_addr,
    .rd_gnt, .mem_en, .mem_we, .mem_addr, .mem_wdata
  );

  hsid_pixel_mem u_pixel_mem (
    .clk, .rst_n, .mem_en, .mem_we, .mem_addr, .mem_wdata, .mem_rdata, .mem_rvalid
  );

  hsid_distance_unit u_distance_unit (
    .clk, .rst_n, .run_start, .phase_capture, .phase_library, .band_packs,
    .hsp_bands, .mem_rdata, .mem_rvalid, .done,
    .abort        (rd_abort),
    .result_valid, .best_index, .best_sse
  );

endmodule

`default_nettype wire

/* tests/hsid_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module hsid_tb;

  import hsid_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_TESTS  = 13;
  localparam int RUN_CYCLES = 63 * 64 * 3 + 500;  // Fill, run and stalls of the longest test
  localparam int STALL_BASE = 3072;               // Above any pixel data

  logic                          clk;
  logic                          rst_n;
  logic                          host_we;
  logic [HSID_WORD_WIDTH-1:0]    host_addr;
  logic [HSID_WORD_WIDTH-1:0]    host_wdata;
  logic [HSID_BANDS_WIDTH-1:0]   hsp_bands;
  logic [HSID_LIBRARY_WIDTH-1:0] hsp_library_size;
  logic [HSID_WORD_WIDTH-1:0]    captured_pixel_addr;
  logic [HSID_WORD_WIDTH-1:0]    library_pixel_addr;
  logic                          start;
  logic                          clear;
  logic                          error;
  logic                          interrupt;
  logic                          result_valid;
  logic [HSID_LIBRARY_WIDTH-1:0] best_index;
  logic [HSID_SSE_WIDTH-1:0]     best_sse;

  logic [31:0] seed;
  logic [31:0] shadow [4096];  // Copy of everything the host wrote
  int          errors;
  int          tests_run;
  int          tests_failed;
  bit          irq_seen;
  bit          irq_at_valid;
  bit          run_timeout;

  hsid_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin : watchdog
    #(NUM_TESTS * RUN_CYCLES * CLK_PERIOD);
    $display("Watchdog expired at %0t ns, a test never finished", $time);
    $display("Regression failed");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    logic [31:0] r;
    r = next_rand();
    return lo + int'((r >> 8) % (hi - lo + 1));  // Low LCG bits are weak
  endfunction

  function automatic int band_sample(input int base, input int band);
    logic [31:0] word;
    word = shadow[(base + band / 2) % 4096];
    return (band % 2 == 1) ? int'(word[31:16]) : int'(word[15:0]);
  endfunction

  task automatic report_error(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic host_write(input int addr, input logic [31:0] data);
    @(posedge clk);
    host_we    <= 1'b1;
    host_addr  <= 32'(addr);
    host_wdata <= data;
    shadow[addr % 4096] = data;
  endtask

  task automatic fill_words(input int base, input int count, input logic [15:0] mask);
    int i;
    for (i = 0; i < count; i++) host_write(base + i, next_rand() & {mask, mask});
    @(posedge clk);
    host_we <= 1'b0;
  endtask

  // Reference sums over the real bands only, lowest index kept on a tie
  task automatic model_result(input int cap_base, input int lib_base, input int bands,
                              input int lib_size, output int exp_index,
                              output longint exp_sse);
    int     packs;
    int     p;
    int     b;
    longint sum;
    longint d;
    packs     = (bands + 1) / 2;
    exp_index = 0;
    exp_sse   = 64'h7fff_ffff_ffff_ffff;
    for (p = 0; p < lib_size; p++) begin
      sum = 0;
      for (b = 0; b < bands; b++) begin
        d   = band_sample(lib_base + p * packs, b) - band_sample(cap_base, b);
        sum = sum + d * d;
      end
      if (sum < exp_sse) begin
        exp_sse   = sum;
        exp_index = p;
      end
    end
  endtask

  task automatic start_run(input int bands, input int lib_size, input int cap_base,
                           input int lib_base);
    @(posedge clk);
    hsp_bands           <= HSID_BANDS_WIDTH'(bands);
    hsp_library_size    <= HSID_LIBRARY_WIDTH'(lib_size);
    captured_pixel_addr <= 32'(cap_base);
    library_pixel_addr  <= 32'(lib_base);
    start               <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic wait_result();
    int n;
    irq_seen = 1'b0;
    n        = 0;
    do begin
      @(negedge clk);
      if (interrupt) irq_seen = 1'b1;
      n++;
    end while (!result_valid && n < RUN_CYCLES);
    run_timeout  = !result_valid;
    irq_at_valid = interrupt;  // The done pulse is already over here
  endtask

  task automatic stall_writes(input int count);
    int i;
    for (i = 0; i < count; i++) begin
      repeat (rand_range(1, 4)) @(posedge clk);
      host_we    <= 1'b1;
      host_addr  <= 32'(STALL_BASE + rand_range(0, 1023));
      host_wdata <= next_rand();
      @(posedge clk);
      host_we <= 1'b0;
    end
  endtask

  task automatic check_run(input int bands, input int lib_size, input int stalls,
                           input logic [15:0] mask);
    int     packs;
    int     cap_base;
    int     lib_base;
    int     exp_index;
    longint exp_sse;
    packs    = (bands + 1) / 2;
    cap_base = rand_range(0, 255);
    lib_base = rand_range(256, 511);
    fill_words(cap_base, packs, mask);
    fill_words(lib_base, packs * lib_size, mask);
    model_result(cap_base, lib_base, bands, lib_size, exp_index, exp_sse);
    start_run(bands, lib_size, cap_base, lib_base);
    repeat (2) @(negedge clk);  // result_valid drops in CONFIG
    if (result_valid) report_error("result_valid still high after start");
    fork
      wait_result();
      stall_writes(stalls);
    join
    if (run_timeout) begin
      $display("Run with %0d bands and %0d pixels never finished", bands, lib_size);
      errors++;
    end else begin
      if (!irq_seen) report_error("interrupt did not pulse on done");
      if (irq_at_valid) report_error("interrupt longer than one cycle");
      if (best_index !== HSID_LIBRARY_WIDTH'(exp_index))
        report_error($sformatf("best_index %0d, expected %0d", best_index, exp_index));
      if (best_sse !== HSID_SSE_WIDTH'(exp_sse))
        report_error($sformatf("best_sse %0d, expected %0d", best_sse, exp_sse));
    end
  endtask

  task automatic check_abort(input bit use_error);
    int bands;
    int lib_size;
    int packs;
    bit irq;
    bands    = rand_range(2, 40);
    lib_size = rand_range(2, 30);
    packs    = (bands + 1) / 2;
    fill_words(0, packs, 16'hffff);
    fill_words(512, packs * lib_size, 16'hffff);
    start_run(bands, lib_size, 0, 512);
    repeat (rand_range(1, packs * (lib_size + 1))) @(posedge clk);  // Lands before done
    if (use_error) error <= 1'b1;
    else clear <= 1'b1;
    @(negedge clk);
    irq = interrupt;
    @(posedge clk);
    clear <= 1'b0;
    error <= 1'b0;
    repeat (2) begin
      @(negedge clk);
      irq = irq | interrupt;  // CLEAR state holds it after a clear
    end
    if (!irq) report_error("interrupt did not rise on abort");
    repeat (packs * (lib_size + 1) + 16) @(negedge clk);  // Past where the run would end
    if (result_valid) report_error("result_valid high after abort");
    if (interrupt) report_error("interrupt still high after abort");
    check_run(rand_range(1, 64), rand_range(1, 63), 0, 16'hffff);
  endtask

  task automatic check_idle();
    int i;
    @(negedge clk);
    if (interrupt) report_error("interrupt high after reset");
    if (result_valid) report_error("result_valid high after reset");
    for (i = 0; i < 16; i++) begin
      host_write(STALL_BASE + i, next_rand());
      @(negedge clk);
      if (DUT.mem_rvalid || DUT.rd_req) report_error("memory read before the first start");
    end
    @(posedge clk);
    host_we <= 1'b0;
  endtask

  task automatic finish_test(input string name, input int mark);
    tests_run++;
    if (errors == mark) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAILED", tests_run, name);
    end
  endtask

  initial begin : main
    int mark;
    int i;
    seed                = 32'h4963_1948;
    errors              = 0;
    tests_run           = 0;
    tests_failed        = 0;
    rst_n               = 1'b0;
    host_we             = 1'b0;
    host_addr           = '0;
    host_wdata          = '0;
    hsp_bands           = '0;
    hsp_library_size    = '0;
    captured_pixel_addr = '0;
    library_pixel_addr  = '0;
    start               = 1'b0;
    clear               = 1'b0;
    error               = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    mark = errors;
    check_idle();
    finish_test("idle after reset", mark);
    for (i = 0; i < 4; i++) begin
      mark = errors;  // Last one uses tiny samples so that sums tie
      check_run(2 * rand_range(1, 32), rand_range(1, 63), 0, (i == 3) ? 16'h0003 : 16'hffff);
      finish_test("even bands", mark);
    end
    for (i = 0; i < 3; i++) begin
      mark = errors;
      check_run(2 * rand_range(0, 31) + 1, rand_range(1, 63), 0, 16'hffff);
      finish_test("odd bands", mark);
    end
    for (i = 0; i < 3; i++) begin
      mark = errors;
      check_run(rand_range(1, 64), rand_range(1, 63), rand_range(8, 24), 16'hffff);
      finish_test("host stalls", mark);
    end
    mark = errors;
    check_abort(1'b0);
    finish_test("clear abort", mark);
    mark = errors;
    check_abort(1'b1);
    finish_test("error abort", mark);
    $display("Tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hsid_top.f */
hdl/hsid_pkg.sv
hdl/hsid_sequencer.sv
hdl/hsid_mem_reader.sv
hdl/hsid_mem_arbiter.sv
hdl/hsid_pixel_mem.sv
hdl/hsid_distance_unit.sv
hdl/hsid_top.sv
tests/hsid_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module hsid_tb \
	  -f hsid_top.f -o Vhsid_tb

run: compile
	./obj_dir/Vhsid_tb > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Regression failed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
